// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Mdir obj_dir
TOP      = tb_sram_subsys
FILELIST = build.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== build.f ====
hw/sram_pkg.sv
hw/wb_pkg.sv
hw/wb_host_port.sv
hw/sram_ctrl_fsm.sv
hw/sram_cycle_timer.sv
hw/sram_data_path.sv
hw/sram_wb.sv
hw/sram_subsys_top.sv
tests/tb_clk_gen.sv
tests/tb_sram_model.sv
tests/tb_sram_subsys.sv

// ==== hw/sram_ctrl_fsm.sv ====
// Sequencer for the Wishbone-to-SRAM bridge.
// Captures a strobed cycle, then runs the low and high half-word accesses
// in turn, each followed by a recovery gap, and finally raises a one-cycle
// acknowledge. Halves that carry no enabled byte are skipped and accesses
// outside the SRAM window go straight to the acknowledge.

`timescale 1ns/1ps

module sram_ctrl_fsm (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_stb,
    input  logic i_we,
    input  logic i_in_window,
    input  logic i_lo_used,
    input  logic i_hi_used,
    input  logic i_timer_done,
    output logic o_timer_start,
    output logic o_timer_recover,
    output logic o_capture,
    output logic o_half_sel,
    output logic o_strobe,
    output logic o_sample,
    output logic o_ack
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        LO_ACCESS,
        LO_RECOVER,
        HI_ACCESS,
        HI_RECOVER,
        ACK
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb begin
        state_next      = state;
        o_timer_start   = 1'b0;
        o_timer_recover = 1'b0;

        case (state)
            IDLE: if (i_stb) state_next = DECODE;
            DECODE: begin
                if (!i_in_window) begin
                    state_next = ACK;
                end else if (i_lo_used) begin
                    state_next    = LO_ACCESS;
                    o_timer_start = 1'b1;
                end else if (i_hi_used) begin
                    state_next    = HI_ACCESS;
                    o_timer_start = 1'b1;
                end else begin
                    state_next = ACK;              // Write with no byte enabled
                end
            end
            LO_ACCESS: if (i_timer_done) begin
                state_next      = LO_RECOVER;
                o_timer_start   = 1'b1;
                o_timer_recover = 1'b1;
            end
            LO_RECOVER: if (i_timer_done) begin
                if (i_hi_used) begin
                    state_next    = HI_ACCESS;
                    o_timer_start = 1'b1;
                end else begin
                    state_next = ACK;
                end
            end
            HI_ACCESS: if (i_timer_done) begin
                state_next      = HI_RECOVER;
                o_timer_start   = 1'b1;
                o_timer_recover = 1'b1;
            end
            HI_RECOVER: if (i_timer_done) state_next = ACK;
            ACK: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign o_capture  = (state == IDLE) && i_stb;
    assign o_strobe   = (state == LO_ACCESS) || (state == HI_ACCESS);
    assign o_half_sel = (state == HI_ACCESS) || (state == HI_RECOVER);
    assign o_sample   = o_strobe && i_timer_done && !i_we;   // Last strobe cycle
    assign o_ack      = (state == ACK);

endmodule

// ==== hw/sram_cycle_timer.sv ====
// Phase timer for the SRAM sequencer. A start pulse loads either the
// strobe length or the recovery length; o_done rises in the cycle the
// count reaches zero. A new start in that same cycle reloads it.

`timescale 1ns/1ps

module sram_cycle_timer (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_recover,
    output logic o_done
);

    import sram_pkg::*;

    sram_count_t count;
    logic        armed;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
            armed <= 1'b0;
        end else if (i_start) begin
            count <= i_recover ? sram_count_t'(SRAM_RECOVER_CYCLES - 1) :
                                 sram_count_t'(SRAM_ACCESS_CYCLES - 1);
            armed <= 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end else begin
            armed <= 1'b0;
        end
    end

    assign o_done = armed && (count == '0);

endmodule

// ==== hw/sram_data_path.sv ====
// Datapath of the Wishbone-to-SRAM bridge.
// Registers the bus request on capture, decodes the address window and
// which half-words a write touches, and drives the SRAM pins from the
// sequencer's strobe and half select. Read halves are gathered into one
// word; reads outside the window return zero.

`timescale 1ns/1ps

module sram_data_path (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  wb_pkg::wb_m2s_t      i_wb,
    input  logic                 i_capture,
    input  logic                 i_half_sel,
    input  logic                 i_strobe,
    input  logic                 i_sample,
    input  sram_pkg::sram_data_t i_sram_dq,
    output logic                 o_in_window,
    output logic                 o_lo_used,
    output logic                 o_hi_used,
    output sram_pkg::sram_pins_t o_pins,
    output wb_pkg::wb_data_t     o_rdata
);

    import sram_pkg::*;
    import wb_pkg::*;

    wb_addr_t offset_q;   // Byte offset into the window
    wb_data_t data_q;
    wb_sel_t  sel_q;
    wb_data_t rdata_q;
    logic     we_q;
    logic     in_window_d;
    logic     lo_used_d;
    logic     hi_used_d;
    logic     write_strobe;
    logic [1:0] lanes;

    assign in_window_d = (i_wb.addr >= SRAM_BASE_ADDR) &&
                         (i_wb.addr < SRAM_BASE_ADDR + SRAM_WINDOW_BYTES);
    assign lo_used_d   = !i_wb.we || (|i_wb.sel[1:0]);
    assign hi_used_d   = !i_wb.we || (|i_wb.sel[3:2]);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            we_q        <= 1'b0;
            o_in_window <= 1'b0;
            o_lo_used   <= 1'b0;
            o_hi_used   <= 1'b0;
        end else if (i_capture) begin
            we_q        <= i_wb.we;
            o_in_window <= in_window_d;
            o_lo_used   <= lo_used_d;
            o_hi_used   <= hi_used_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) begin
            offset_q <= i_wb.addr - SRAM_BASE_ADDR;
            data_q   <= i_wb.data;
            sel_q    <= i_wb.sel;
        end
        if (i_sample) begin
            if (i_half_sel)
                rdata_q[WB_DATA_WIDTH-1:SRAM_DATA_WIDTH] <= i_sram_dq;
            else
                rdata_q[SRAM_DATA_WIDTH-1:0] <= i_sram_dq;
        end
    end

    assign lanes        = i_half_sel ? sel_q[3:2] : sel_q[1:0];
    assign write_strobe = i_strobe && we_q;

    always_comb begin
        o_pins.ce_n   = !i_strobe;
        o_pins.oe_n   = !(i_strobe && !we_q);
        o_pins.we_n   = !write_strobe;
        o_pins.ub_n   = !(i_strobe && (!we_q || lanes[1]));   // Reads take both lanes
        o_pins.lb_n   = !(i_strobe && (!we_q || lanes[0]));
        o_pins.addr   = {offset_q[SRAM_ADDR_WIDTH:2], i_half_sel};
        o_pins.dq_out = i_half_sel ? data_q[WB_DATA_WIDTH-1:SRAM_DATA_WIDTH] :
                                     data_q[SRAM_DATA_WIDTH-1:0];
    end

    assign o_rdata = o_in_window ? rdata_q : '0;

endmodule

// ==== hw/sram_pkg.sv ====
// Definitions for the external asynchronous SRAM side of the subsystem.
// Holds the pin widths, the strobe and recovery timing in clock cycles,
// and the packed pin bundle that the bridge drives toward the pads.
// Import it where SRAM pins, half-words or the cycle timer are handled.

package sram_pkg;

    localparam int SRAM_ADDR_WIDTH = 20;      // Half-word address
    localparam int SRAM_DATA_WIDTH = 16;

    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
    typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;

    // Strobe length, data sampled on its last cycle
    localparam int SRAM_ACCESS_CYCLES  = 2;
    localparam int SRAM_RECOVER_CYCLES = 1;   // Idle gap between accesses

    localparam int SRAM_TIMER_MAX   = (SRAM_ACCESS_CYCLES > SRAM_RECOVER_CYCLES) ?
                                      SRAM_ACCESS_CYCLES : SRAM_RECOVER_CYCLES;
    localparam int SRAM_TIMER_WIDTH = $clog2(SRAM_TIMER_MAX + 1);

    typedef logic [SRAM_TIMER_WIDTH-1:0] sram_count_t;

    typedef struct packed {
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
        logic       ub_n;
        logic       lb_n;
        sram_addr_t addr;
        sram_data_t dq_out;   // Valid while we_n is low
    } sram_pins_t;

endpackage

// ==== hw/sram_subsys_top.sv ====
// Top level of the SRAM memory subsystem.
// A host issues requests over a four-phase req/ack handshake; they run as
// Wishbone cycles into the SRAM bridge, whose pin bundle is broken out to
// the pads here. The data bus is split, o_sram_dq is valid while
// o_sram_we_n is low.

`timescale 1ns/1ps

module sram_subsys_top (
    input  logic                 clk,
    input  logic                 i_rst_n,

    // Host
    input  logic                 i_req,
    input  wb_pkg::host_req_t    i_host_req,
    output logic                 o_ack,
    output wb_pkg::wb_data_t     o_rdata,

    // SRAM
    output sram_pkg::sram_addr_t o_sram_addr,
    input  sram_pkg::sram_data_t i_sram_dq,
    output sram_pkg::sram_data_t o_sram_dq,
    output logic                 o_sram_ce_n,
    output logic                 o_sram_we_n,
    output logic                 o_sram_oe_n,
    output logic                 o_sram_ub_n,
    output logic                 o_sram_lb_n
);

    import sram_pkg::*;
    import wb_pkg::*;

    wb_m2s_t    wb_m2s;
    wb_s2m_t    wb_s2m;
    sram_pins_t pins;

    wb_host_port u_host (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_host_req (i_host_req),
        .o_ack      (o_ack),
        .o_rdata    (o_rdata),
        .o_wb       (wb_m2s),
        .i_wb       (wb_s2m)
    );

    sram_wb u_bridge (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_wb      (wb_m2s),
        .o_wb      (wb_s2m),
        .o_pins    (pins),
        .i_sram_dq (i_sram_dq)
    );

    assign o_sram_addr = pins.addr;
    assign o_sram_dq   = pins.dq_out;
    assign o_sram_ce_n = pins.ce_n;
    assign o_sram_we_n = pins.we_n;
    assign o_sram_oe_n = pins.oe_n;
    assign o_sram_ub_n = pins.ub_n;
    assign o_sram_lb_n = pins.lb_n;

endmodule

// ==== hw/sram_wb.sv ====
// Wishbone classic slave that maps a 32-bit bus onto a 16-bit async SRAM.
// Each word becomes up to two half-word accesses, low half first at the
// even address. The sequencer, phase timer and datapath are joined here.

`timescale 1ns/1ps

module sram_wb (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  wb_pkg::wb_m2s_t      i_wb,
    output wb_pkg::wb_s2m_t      o_wb,
    output sram_pkg::sram_pins_t o_pins,
    input  sram_pkg::sram_data_t i_sram_dq
);

    logic in_window;
    logic lo_used;
    logic hi_used;
    logic timer_done;
    logic timer_start;
    logic timer_recover;
    logic capture;
    logic half_sel;
    logic strobe;
    logic sample;

    sram_ctrl_fsm u_ctrl (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_stb           (i_wb.cyc && i_wb.stb),
        .i_we            (i_wb.we),
        .i_in_window     (in_window),
        .i_lo_used       (lo_used),
        .i_hi_used       (hi_used),
        .i_timer_done    (timer_done),
        .o_timer_start   (timer_start),
        .o_timer_recover (timer_recover),
        .o_capture       (capture),
        .o_half_sel      (half_sel),
        .o_strobe        (strobe),
        .o_sample        (sample),
        .o_ack           (o_wb.ack)
    );

    sram_cycle_timer u_timer (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_start   (timer_start),
        .i_recover (timer_recover),
        .o_done    (timer_done)
    );

    sram_data_path u_data (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_wb        (i_wb),
        .i_capture   (capture),
        .i_half_sel  (half_sel),
        .i_strobe    (strobe),
        .i_sample    (sample),
        .i_sram_dq   (i_sram_dq),
        .o_in_window (in_window),
        .o_lo_used   (lo_used),
        .o_hi_used   (hi_used),
        .o_pins      (o_pins),
        .o_rdata     (o_wb.data)
    );

endmodule

// ==== hw/wb_host_port.sv ====
// Host side of the subsystem. Accepts one request at a time over a
// four-phase req/ack handshake and runs it as a single Wishbone classic
// cycle. Read data is held on o_rdata for as long as o_ack stays high;
// writes return zero.

`timescale 1ns/1ps

module wb_host_port (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_req,
    input  wb_pkg::host_req_t  i_host_req,
    output logic               o_ack,
    output wb_pkg::wb_data_t   o_rdata,
    output wb_pkg::wb_m2s_t    o_wb,
    input  wb_pkg::wb_s2m_t    i_wb
);

    import wb_pkg::*;

    typedef enum logic [1:0] {IDLE, BUS, HANDOFF} state_t;

    state_t    state;
    logic      bus_q;
    host_req_t req_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
            bus_q <= 1'b0;
            o_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: if (i_req) begin
                    state <= BUS;
                    bus_q <= 1'b1;
                end
                BUS: if (i_wb.ack) begin
                    state <= HANDOFF;
                    bus_q <= 1'b0;
                    o_ack <= 1'b1;
                end
                HANDOFF: if (!i_req) begin     // Host released, finish the return
                    state <= IDLE;
                    o_ack <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && i_req)
            req_q <= i_host_req;
        if (state == BUS && i_wb.ack)
            o_rdata <= req_q.we ? '0 : i_wb.data;
    end

    assign o_wb = '{cyc: bus_q, stb: bus_q, we: req_q.we, sel: req_q.sel,
                    addr: req_q.addr, data: req_q.wdata};

endmodule

// ==== hw/wb_pkg.sv ====
// Definitions for the bus side of the memory subsystem.
// Covers the Wishbone classic widths, the byte window that maps onto the
// SRAM, the master and slave signal bundles, and the host request that
// the host port turns into a single bus cycle.

package wb_pkg;

    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [WB_SEL_WIDTH-1:0]  wb_sel_t;

    // Byte window served by the SRAM, 1M half-words
    localparam wb_addr_t SRAM_BASE_ADDR    = 32'h0010_0000;
    localparam wb_addr_t SRAM_WINDOW_BYTES = 32'h0020_0000;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_sel_t  sel;
        wb_addr_t addr;
        wb_data_t data;
    } wb_m2s_t;

    typedef struct packed {
        logic     ack;    // Single cycle
        wb_data_t data;
    } wb_s2m_t;

    typedef struct packed {
        logic     we;
        wb_addr_t addr;
        wb_sel_t  sel;
        wb_data_t wdata;
    } host_req_t;

endpackage

// ==== tests/tb_clk_gen.sv ====
// Clock and reset source for the subsystem testbench.
// 8 ns clock; reset held low for 16 cycles, released just after an edge.

`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_sram_model.sv ====
// Behavioural 16-bit asynchronous SRAM for the subsystem testbench.
// Reads are combinational while ce_n and oe_n are low; a write lands on
// the rising edge of we_n for the enabled byte lanes. Counts we_n and
// ce_n falls so the testbench can see how many accesses were made.

`timescale 1ns/1ps

module tb_sram_model (
    input  sram_pkg::sram_addr_t i_addr,
    input  sram_pkg::sram_data_t i_dq,
    output sram_pkg::sram_data_t o_dq,
    input  logic                 i_ce_n,
    input  logic                 i_oe_n,
    input  logic                 i_we_n,
    input  logic                 i_ub_n,
    input  logic                 i_lb_n,
    output int                   o_we_falls,
    output int                   o_ce_falls
);

    import sram_pkg::*;

    sram_data_t mem [0:(1 << SRAM_ADDR_WIDTH)-1];
    sram_addr_t wr_addr;
    sram_data_t wr_data;
    logic [1:0] wr_lanes;
    logic       wr_en = 1'b0;
    int         we_falls = 0;
    int         ce_falls = 0;

    assign o_dq       = (!i_ce_n && !i_oe_n) ? mem[i_addr] : '0;
    assign o_we_falls = we_falls;
    assign o_ce_falls = ce_falls;

    always @(negedge i_ce_n) ce_falls++;

    always @(negedge i_we_n) begin
        we_falls++;
        #1;                                  // Lanes and address settle
        wr_addr  = i_addr;
        wr_data  = i_dq;
        wr_lanes = {!i_ub_n, !i_lb_n};
        wr_en    = !i_ce_n;
    end

    always @(posedge i_we_n) begin
        if (wr_en && wr_lanes[0])
            mem[wr_addr][7:0] = wr_data[7:0];
        if (wr_en && wr_lanes[1])
            mem[wr_addr][15:8] = wr_data[15:8];
    end

endmodule

// ==== tests/tb_sram_subsys.sv ====
// Testbench for the SRAM memory subsystem.
// Random host requests run through the four-phase port; a shadow word
// array predicts read data. Covers reset state, word traffic, byte-lane
// merging, half skipping, the out-of-window path and the handshake.

`timescale 1ns/1ps

module tb_sram_subsys;

    import sram_pkg::*;
    import wb_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_WORDS      = 200;

    logic        clk;
    logic        rst_n;
    logic        req;
    host_req_t   host_req;
    logic        ack;
    wb_data_t    rdata;
    sram_addr_t  sram_addr;
    sram_data_t  dq_to_dut;
    sram_data_t  dq_from_dut;
    logic        ce_n;
    logic        we_n;
    logic        oe_n;
    logic        ub_n;
    logic        lb_n;
    int          we_falls;
    int          ce_falls;
    logic [31:0] lfsr = 32'h59959e17;
    wb_data_t    shadow [int unsigned];   // Word index into the window
    int unsigned pool [$];
    int          errors = 0;
    int          test_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    event        hang_ev;

    tb_clk_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

    tb_sram_model u_sram (
        .i_addr     (sram_addr),
        .i_dq       (dq_from_dut),
        .o_dq       (dq_to_dut),
        .i_ce_n     (ce_n),
        .i_oe_n     (oe_n),
        .i_we_n     (we_n),
        .i_ub_n     (ub_n),
        .i_lb_n     (lb_n),
        .o_we_falls (we_falls),
        .o_ce_falls (ce_falls)
    );

    sram_subsys_top uut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_req       (req),
        .i_host_req  (host_req),
        .o_ack       (ack),
        .o_rdata     (rdata),
        .o_sram_addr (sram_addr),
        .i_sram_dq   (dq_to_dut),
        .o_sram_dq   (dq_from_dut),
        .o_sram_ce_n (ce_n),
        .o_sram_we_n (we_n),
        .o_sram_oe_n (oe_n),
        .o_sram_ub_n (ub_n),
        .o_sram_lb_n (lb_n)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic wb_data_t merge_bytes(input wb_data_t old, input wb_data_t wd,
                                             input wb_sel_t sel);
        wb_data_t m;
        for (int b = 0; b < 4; b++)
            m[b*8 +: 8] = sel[b] ? wd[b*8 +: 8] : old[b*8 +: 8];
        return m;
    endfunction

    function automatic wb_addr_t word_addr(input int unsigned idx);
        return SRAM_BASE_ADDR + (idx << 2);
    endfunction

    task automatic report(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s within %0d cycles at %0t ns", what, TIMEOUT_CYCLES, $time);
        -> hang_ev;
        @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_start)
            tests_failed++;
        $display("%-14s %s (%0d errors)", name,
                 (errors == test_start) ? "ok" : "FAILED", errors - test_start);
        test_start = errors;
    endtask

    // One four-phase transfer; hold keeps i_req high for extra cycles
    task automatic host_access(input logic we, input wb_addr_t addr, input wb_sel_t sel,
                               input wb_data_t wd, input int hold, output wb_data_t rd);
        int n;
        int ce0;
        host_req = '{we: we, addr: addr, sel: sel, wdata: wd};
        req      = 1'b1;
        n        = 0;
        while (!ack && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ack)
            abort_on_timeout("o_ack did not rise");
        rd  = rdata;
        ce0 = ce_falls;
        repeat (hold) begin
            @(posedge clk);
            #1;
            assert (ack && rdata == rd && ce_falls == ce0)
                else report("held o_ack/o_rdata", rdata, rd);
        end
        req = 1'b0;
        n   = 0;
        while (ack && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack)
            abort_on_timeout("o_ack did not fall");
        assert (n == 1) else report("o_ack fall delay", n, 1);
    endtask

    // Low half lives at the even SRAM address, high half at the odd one
    task automatic write_word(input int unsigned idx, input wb_sel_t sel, input wb_data_t wd,
                              input int hold);
        wb_data_t   rd;
        sram_addr_t lo_addr;
        host_access(1'b1, word_addr(idx), sel, wd, hold, rd);
        shadow[idx] = merge_bytes(shadow.exists(idx) ? shadow[idx] : '0, wd, sel);
        assert (rd == '0) else report("write rdata", rd, '0);
        lo_addr = sram_addr_t'(idx << 1);
        assert (u_sram.mem[lo_addr] == shadow[idx][15:0] &&
                u_sram.mem[lo_addr + 1'b1] == shadow[idx][31:16])
            else report("SRAM half-words", {u_sram.mem[lo_addr + 1'b1], u_sram.mem[lo_addr]},
                        shadow[idx]);
    endtask

    task automatic read_check(input int unsigned idx, input int hold);
        wb_data_t rd;
        host_access(1'b0, word_addr(idx), 4'hf, '0, hold, rd);
        assert (rd == shadow[idx]) else report("read data", rd, shadow[idx]);
    endtask

    initial begin
        @(hang_ev);
        $display("Test failed");
        $finish;
    end

    initial begin
        wb_data_t    rd;
        wb_addr_t    addr;
        wb_sel_t     sel;
        int unsigned idx;
        int          n;
        int          kind;
        int          falls0;
        int          exp_falls;

        req      = 1'b0;
        host_req = '0;
        n        = 0;
        while (!rst_n && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n)
            abort_on_timeout("reset was not released");
        @(posedge clk);
        #1;
        assert (!ack && ce_n && we_n && oe_n && ub_n && lb_n)
            else report("ack,ce_n,we_n,oe_n,ub_n,lb_n after reset",
                        {26'b0, ack, ce_n, we_n, oe_n, ub_n, lb_n}, 32'h1f);
        finish_test("reset_state");

        for (int i = 0; i < NUM_WORDS; i++) begin
            idx = rand_bits(19);
            write_word(idx, 4'hf, rand_bits(32), 0);
            pool.push_back(idx);
        end
        foreach (pool[i]) read_check(pool[i], 0);
        finish_test("word_rw");

        for (int i = 0; i < 100; i++) begin
            idx = pool[rand_bits(8) % pool.size()];
            sel = wb_sel_t'(rand_bits(4));
            write_word(idx, sel, rand_bits(32), 0);
            read_check(idx, 0);
        end
        finish_test("byte_merge");

        for (int i = 0; i < 40; i++) begin
            idx    = pool[rand_bits(8) % pool.size()];
            kind   = rand_bits(2);
            sel    = wb_sel_t'(rand_bits(2));
            sel    = (sel == '0) ? 4'b0001 : sel;
            sel    = rand_bits(1) ? {sel[1:0], 2'b00} : sel;   // One half only
            falls0 = we_falls;
            if (kind == 0) begin
                read_check(idx, 0);
                exp_falls = 0;
            end else if (kind == 1) begin
                write_word(idx, 4'hf, rand_bits(32), 0);
                exp_falls = 2;
            end else begin
                write_word(idx, sel, rand_bits(32), 0);
                exp_falls = 1;
            end
            assert (we_falls - falls0 == exp_falls)
                else report("we_n falls", we_falls - falls0, exp_falls);
        end
        finish_test("half_skip");

        for (int i = 0; i < 40; i++) begin
            addr   = rand_bits(1) ? rand_bits(20) :
                                    SRAM_BASE_ADDR + SRAM_WINDOW_BYTES + rand_bits(24);
            falls0 = ce_falls;
            if (rand_bits(1)) begin
                host_access(1'b0, addr, 4'hf, '0, 0, rd);
                assert (rd == '0) else report("out-of-window read", rd, '0);
            end else begin
                host_access(1'b1, addr, 4'hf, rand_bits(32), 0, rd);
            end
            assert (ce_falls == falls0) else report("ce_n falls", ce_falls - falls0, 0);
        end
        foreach (pool[i]) read_check(pool[i], 0);     // Nothing aliased into the window
        finish_test("out_of_window");

        for (int i = 0; i < 40; i++) begin
            idx = pool[rand_bits(8) % pool.size()];
            n   = rand_bits(3) + 1;
            if (rand_bits(1))
                read_check(idx, n);
            else
                write_word(idx, wb_sel_t'(rand_bits(4)), rand_bits(32), n);
        end
        finish_test("handshake");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
